// ==== logic/mem_stage_params.svh ====
// widths and funct3 codes for the memory stage; RAM_AW above 30 will not fit the address
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// ==============================
// widths
`define XLEN    32
`define REG_W   5
`define RAM_AW  8

// ==============================
// load size codes (funct3)
`define F3_LB   3'b000
`define F3_LH   3'b001
`define F3_LW   3'b010
`define F3_LBU  3'b100
`define F3_LHU  3'b101

// store size codes (funct3)
`define F3_SB   3'b000
`define F3_SH   3'b001
`define F3_SW   3'b010

`endif

// ==== logic/mem_pkg.sv ====
// memory word views for the data RAM; assumes XLEN is 32 (four bytes, two halves)
`include "mem_stage_params.svh"

`default_nettype none

package mem_pkg;

    // ==============================
    // one RAM word, seen as bytes or halves
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]  b;
        logic [`XLEN/16-1:0][15:0] h;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== logic/data_ram.sv ====
// single port word RAM, one cycle read latency, contents undefined until written
`include "mem_stage_params.svh"

`default_nettype none

module data_ram (
    input  logic                clk,
    input  logic                ram_re,
    input  logic                ram_we,
    input  logic [`RAM_AW-1:0]  ram_addr,
    input  logic [`XLEN/8-1:0]  ram_be,
    input  mem_pkg::mem_word_u  ram_wdata,
    output mem_pkg::mem_word_u  ram_rdata
);

    localparam int DEPTH = 1 << `RAM_AW;

    mem_pkg::mem_word_u mem [DEPTH];

    // masked byte writes
    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (ram_be[i]) begin
                    mem[ram_addr].b[i] <= ram_wdata.b[i];
                end
            end
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        if (ram_re) begin
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_align.sv ====
// byte lane steering and load extension; unknown funct3 codes act as word size
`include "mem_stage_params.svh"

`default_nettype none

module mem_align (
    input  logic [`XLEN-1:0]    in_alu_out,
    input  logic [`XLEN-1:0]    in_rs2_data,
    input  logic [2:0]          in_funct3,
    input  logic                in_mem_read,
    input  logic                in_mem_write,
    input  mem_pkg::mem_word_u  ram_rdata,
    output logic [`RAM_AW-1:0]  ram_addr,
    output mem_pkg::mem_word_u  ram_wdata,
    output logic [`XLEN/8-1:0]  ram_be,
    output logic [`XLEN-1:0]    load_data,
    output logic                misalign
);

    logic [1:0]  byte_off;
    logic        addr_bad;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    assign byte_off = in_alu_out[1:0];
    assign ram_addr = in_alu_out[`RAM_AW+1:2];

    // ==============================
    // alignment check
    always_comb begin
        case (in_funct3[1:0])
            2'b01:   addr_bad = byte_off[0];
            2'b00:   addr_bad = 1'b0;
            default: addr_bad = |byte_off;
        endcase
    end

    assign misalign = (in_mem_read | in_mem_write) & addr_bad;

    // ==============================
    // store lanes
    always_comb begin
        ram_wdata = in_rs2_data;
        ram_be    = '1;
        case (in_funct3)
            `F3_SB: begin
                ram_wdata.b       = {(`XLEN/8){in_rs2_data[7:0]}};
                ram_be            = '0;
                ram_be[byte_off]  = 1'b1;
            end
            `F3_SH: begin
                ram_wdata.h = {(`XLEN/16){in_rs2_data[15:0]}};
                ram_be      = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                ram_wdata = in_rs2_data;
                ram_be    = '1;
            end
        endcase
    end

    // ==============================
    // load extraction
    assign rd_byte = ram_rdata.b[byte_off];
    assign rd_half = ram_rdata.h[byte_off[1]];

    always_comb begin
        case (in_funct3)
            `F3_LB:  load_data = {{(`XLEN-8){rd_byte[7]}}, rd_byte};
            `F3_LBU: load_data = {{(`XLEN-8){1'b0}}, rd_byte};
            `F3_LH:  load_data = {{(`XLEN-16){rd_half[15]}}, rd_half};
            `F3_LHU: load_data = {{(`XLEN-16){1'b0}}, rd_half};
            default: load_data = ram_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mem_ctrl.sv ====
// load sequencing; a stalled load must come back with in_valid high on the next cycle
`include "mem_stage_params.svh"

`default_nettype none

module mem_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic                in_mem_read,
    input  logic                in_mem_write,
    input  logic                misalign,
    input  logic [`XLEN-1:0]    in_alu_out,
    input  logic [`XLEN-1:0]    load_data,
    output logic                ram_re,
    output logic                ram_we,
    output logic                stall,
    output logic                out_valid,
    output logic                out_misalign,
    output logic                load_done,
    output logic [`XLEN-1:0]    out_result
);

    localparam logic ST_IDLE      = 1'b0;
    localparam logic ST_LOAD_WAIT = 1'b1;

    logic state;
    logic state_nxt;
    logic load_ok;
    logic store_ok;

    // accesses that actually touch the RAM
    assign load_ok  = in_valid & in_mem_read & ~misalign;
    assign store_ok = in_valid & in_mem_write & ~misalign;

    // ==============================
    // fsm
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (load_ok) begin
                    state_nxt = ST_LOAD_WAIT;
                end
            end
            ST_LOAD_WAIT: begin
                // held load retires here
                if (in_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // ==============================
    // strobes and retire
    assign ram_re    = load_ok & (state == ST_IDLE);
    assign ram_we    = store_ok & (state == ST_IDLE);
    assign stall     = ram_re;
    assign load_done = in_valid & (state == ST_LOAD_WAIT);

    // loads retire only from load_wait, everything else goes straight through
    assign out_valid    = load_done | (in_valid & ~load_ok);
    assign out_misalign = in_valid & misalign;
    assign out_result   = load_done ? load_data : in_alu_out;

endmodule

`default_nettype wire

// ==== logic/fwd_unit.sv ====
// MEM over WB forwarding; no hit while a load is still waiting on the RAM
`include "mem_stage_params.svh"

`default_nettype none

module fwd_unit (
    input  logic                in_valid,
    input  logic                in_write_gpr,
    input  logic [`REG_W-1:0]   in_rd,
    input  logic                in_mem_read,
    input  logic                load_done,
    input  logic                misalign,
    input  logic [`XLEN-1:0]    in_alu_out,
    input  logic [`XLEN-1:0]    load_data,
    input  logic [`REG_W-1:0]   wb_rd,
    input  logic                wb_write_gpr,
    input  logic [`XLEN-1:0]    wb_data,
    input  logic [`REG_W-1:0]   ex_rs1,
    input  logic [`REG_W-1:0]   ex_rs2,
    input  logic [`REG_W-1:0]   id_rs1,
    input  logic [`REG_W-1:0]   id_rs2,
    output logic [`XLEN-1:0]    fwd_ex_rs1_data,
    output logic                fwd_ex_rs1_hit,
    output logic [`XLEN-1:0]    fwd_ex_rs2_data,
    output logic                fwd_ex_rs2_hit,
    output logic [`XLEN-1:0]    fwd_id_rs1_data,
    output logic                fwd_id_rs1_hit,
    output logic [`XLEN-1:0]    fwd_id_rs2_data,
    output logic                fwd_id_rs2_hit
);

    localparam int N_SRC = 4;

    logic [N_SRC-1:0][`REG_W-1:0] src_idx;
    logic [N_SRC-1:0][`XLEN-1:0]  src_data;
    logic [N_SRC-1:0]             src_hit;
    logic                         mem_fwd_ok;
    logic [`XLEN-1:0]             mem_val;

    // slot 0 is ex rs1, then ex rs2, id rs1 and id rs2
    assign src_idx = {id_rs2, id_rs1, ex_rs2, ex_rs1};

    // ==============================
    // MEM source
    // a load only forwards once its data is back, a misaligned one never
    assign mem_fwd_ok = in_valid & in_write_gpr &
                        ~(in_mem_read & (misalign | ~load_done));
    assign mem_val    = load_done ? load_data : in_alu_out;

    // ==============================
    // per-index compare
    generate
        for (genvar g = 0; g < N_SRC; g++) begin : g_src
            logic nz;
            logic mem_match;
            logic wb_match;

            assign nz        = |src_idx[g];
            assign mem_match = nz & mem_fwd_ok & (src_idx[g] == in_rd);
            assign wb_match  = nz & wb_write_gpr & (src_idx[g] == wb_rd);

            assign src_hit[g]  = mem_match | wb_match;
            assign src_data[g] = mem_match ? mem_val :
                                 wb_match  ? wb_data : '0;
        end
    endgenerate

    assign fwd_ex_rs1_data = src_data[0];
    assign fwd_ex_rs1_hit  = src_hit[0];
    assign fwd_ex_rs2_data = src_data[1];
    assign fwd_ex_rs2_hit  = src_hit[1];
    assign fwd_id_rs1_data = src_data[2];
    assign fwd_id_rs1_hit  = src_hit[2];
    assign fwd_id_rs2_data = src_data[3];
    assign fwd_id_rs2_hit  = src_hit[3];

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
// memory stage top; upstream must re-present a stalled instruction, writeback never stalls
`include "mem_stage_params.svh"

`default_nettype none

module mem_stage (
    input  logic                clk,
    input  logic                arst_n,
    // ==============================
    // instruction from execute
    input  logic                in_valid,
    input  logic [`XLEN-1:0]    in_pc,
    input  logic [`XLEN-1:0]    in_alu_out,
    input  logic [`XLEN-1:0]    in_rs2_data,
    input  logic [`REG_W-1:0]   in_rd,
    input  logic                in_write_gpr,
    input  logic                in_mem_read,
    input  logic                in_mem_write,
    input  logic [2:0]          in_funct3,
    // ==============================
    // writeback and consumer indices for forwarding
    input  logic [`REG_W-1:0]   wb_rd,
    input  logic                wb_write_gpr,
    input  logic [`XLEN-1:0]    wb_data,
    input  logic [`REG_W-1:0]   ex_rs1,
    input  logic [`REG_W-1:0]   ex_rs2,
    input  logic [`REG_W-1:0]   id_rs1,
    input  logic [`REG_W-1:0]   id_rs2,
    // ==============================
    // retire side
    output logic                stall,
    output logic                out_valid,
    output logic [`XLEN-1:0]    out_pc,
    output logic [`REG_W-1:0]   out_rd,
    output logic                out_write_gpr,
    output logic [`XLEN-1:0]    out_result,
    output logic                out_misalign,
    // ==============================
    // forward outputs
    output logic [`XLEN-1:0]    fwd_ex_rs1_data,
    output logic                fwd_ex_rs1_hit,
    output logic [`XLEN-1:0]    fwd_ex_rs2_data,
    output logic                fwd_ex_rs2_hit,
    output logic [`XLEN-1:0]    fwd_id_rs1_data,
    output logic                fwd_id_rs1_hit,
    output logic [`XLEN-1:0]    fwd_id_rs2_data,
    output logic                fwd_id_rs2_hit
);

    logic                   ram_re;
    logic                   ram_we;
    logic [`RAM_AW-1:0]     ram_addr;
    logic [`XLEN/8-1:0]     ram_be;
    mem_pkg::mem_word_u     ram_wdata;
    mem_pkg::mem_word_u     ram_rdata;
    logic [`XLEN-1:0]       load_data;
    logic                   misalign;
    logic                   load_done;

    // passthrough to writeback
    assign out_pc        = in_pc;
    assign out_rd        = in_rd;
    assign out_write_gpr = in_write_gpr;

    mem_ctrl i_mem_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_mem_read  (in_mem_read),
        .in_mem_write (in_mem_write),
        .misalign     (misalign),
        .in_alu_out   (in_alu_out),
        .load_data    (load_data),
        .ram_re       (ram_re),
        .ram_we       (ram_we),
        .stall        (stall),
        .out_valid    (out_valid),
        .out_misalign (out_misalign),
        .load_done    (load_done),
        .out_result   (out_result)
    );

    mem_align i_mem_align (
        .in_alu_out   (in_alu_out),
        .in_rs2_data  (in_rs2_data),
        .in_funct3    (in_funct3),
        .in_mem_read  (in_mem_read),
        .in_mem_write (in_mem_write),
        .ram_rdata    (ram_rdata),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_be       (ram_be),
        .load_data    (load_data),
        .misalign     (misalign)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .ram_re    (ram_re),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    fwd_unit i_fwd_unit (
        .in_valid        (in_valid),
        .in_write_gpr    (in_write_gpr),
        .in_rd           (in_rd),
        .in_mem_read     (in_mem_read),
        .load_done       (load_done),
        .misalign        (misalign),
        .in_alu_out      (in_alu_out),
        .load_data       (load_data),
        .wb_rd           (wb_rd),
        .wb_write_gpr    (wb_write_gpr),
        .wb_data         (wb_data),
        .ex_rs1          (ex_rs1),
        .ex_rs2          (ex_rs2),
        .id_rs1          (id_rs1),
        .id_rs2          (id_rs2),
        .fwd_ex_rs1_data (fwd_ex_rs1_data),
        .fwd_ex_rs1_hit  (fwd_ex_rs1_hit),
        .fwd_ex_rs2_data (fwd_ex_rs2_data),
        .fwd_ex_rs2_hit  (fwd_ex_rs2_hit),
        .fwd_id_rs1_data (fwd_id_rs1_data),
        .fwd_id_rs1_hit  (fwd_id_rs1_hit),
        .fwd_id_rs2_data (fwd_id_rs2_data),
        .fwd_id_rs2_hit  (fwd_id_rs2_hit)
    );

endmodule

`default_nettype wire

// ==== verif/mem_stage_assert.sv ====
// bound into mem_stage; the stall rule holds only if a stalled load is re-presented next cycle
`include "mem_stage_params.svh"

`default_nettype none

module mem_stage_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     stall,
    input logic                     out_valid,
    input logic                     ram_we,
    input logic                     misalign,
    input logic [3:0][`REG_W-1:0]   idx,
    input logic [3:0]               hit
);

    a_stall_single: assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && $past(stall)))
        else $error("stall high for two cycles in a row");

    a_stall_no_retire: assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && out_valid))
        else $error("stall and out_valid high together");

    a_no_misaligned_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(ram_we && misalign))
        else $error("RAM write on a misaligned access");

    // consumer order is ex rs1, ex rs2, id rs1, id rs2
    for (genvar g = 0; g < 4; g++) begin : g_x0
        a_no_x0_hit: assert property (@(posedge clk) disable iff (!arst_n)
            !(idx[g] == '0 && hit[g]))
            else $error("forward hit for x0 on consumer %0d", g);
    end

endmodule

bind mem_stage mem_stage_assert i_mem_stage_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .out_valid (out_valid),
    .ram_we    (ram_we),
    .misalign  (misalign),
    .idx       ({id_rs2, id_rs1, ex_rs2, ex_rs1}),
    .hit       ({fwd_id_rs2_hit, fwd_id_rs1_hit, fwd_ex_rs2_hit, fwd_ex_rs1_hit})
);

`default_nettype wire

// ==== verif/mem_stage_tb.sv ====
// random test over a 64-word RAM window, which word stores fill before any load runs
`include "mem_stage_params.svh"

`default_nettype none

module mem_stage_tb;

    localparam int N_WORDS  = 64;
    localparam int N_INSTR  = 2000;
    localparam int WAIT_MAX = 20;

    typedef logic [`XLEN:0] chk_t;

    logic                clk;
    logic                arst_n;
    logic                in_valid, in_write_gpr, in_mem_read, in_mem_write;
    logic [`XLEN-1:0]    in_pc, in_alu_out, in_rs2_data;
    logic [`REG_W-1:0]   in_rd, wb_rd, ex_rs1, ex_rs2, id_rs1, id_rs2;
    logic [2:0]          in_funct3;
    logic                wb_write_gpr;
    logic [`XLEN-1:0]    wb_data;
    logic                stall, out_valid, out_write_gpr, out_misalign;
    logic [`XLEN-1:0]    out_pc, out_result;
    logic [`REG_W-1:0]   out_rd;
    logic                fwd_ex_rs1_hit, fwd_ex_rs2_hit, fwd_id_rs1_hit, fwd_id_rs2_hit;
    logic [`XLEN-1:0]    fwd_ex_rs1_data, fwd_ex_rs2_data, fwd_id_rs1_data, fwd_id_rs2_data;

    // mirror of the RAM window with four byte lanes per word
    logic [3:0][7:0]     mem_model [N_WORDS];
    int                  errors;
    int                  timeouts;

    mem_stage i_mem_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check(input string name, input chk_t got, input chk_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    // MEM beats WB and x0 is never forwarded
    function automatic chk_t fwd_expect(input logic [`REG_W-1:0] idx, input logic mem_ok,
                                        input logic [`XLEN-1:0] mem_val);
        if (idx != '0 && mem_ok && idx == in_rd) begin
            return {1'b1, mem_val};
        end else if (idx != '0 && wb_write_gpr && idx == wb_rd) begin
            return {1'b1, wb_data};
        end
        return '0;
    endfunction

    task automatic check_outputs(input logic exp_stall, input logic exp_valid,
                                 input logic exp_mis, input logic [`XLEN-1:0] exp_result,
                                 input logic mem_ok, input logic [`XLEN-1:0] mem_val);
        check("stall", chk_t'(stall), chk_t'(exp_stall));
        check("out_valid", chk_t'(out_valid), chk_t'(exp_valid));
        if (exp_valid) begin
            check("out_result", chk_t'(out_result), chk_t'(exp_result));
            check("out_misalign", chk_t'(out_misalign), chk_t'(exp_mis));
            check("out_rd", chk_t'(out_rd), chk_t'(in_rd));
            check("out_pc", chk_t'(out_pc), chk_t'(in_pc));
            check("out_write_gpr", chk_t'(out_write_gpr), chk_t'(in_write_gpr));
        end
        check("fwd_ex_rs1", {fwd_ex_rs1_hit, fwd_ex_rs1_data},
              fwd_expect(ex_rs1, mem_ok, mem_val));
        check("fwd_ex_rs2", {fwd_ex_rs2_hit, fwd_ex_rs2_data},
              fwd_expect(ex_rs2, mem_ok, mem_val));
        check("fwd_id_rs1", {fwd_id_rs1_hit, fwd_id_rs1_data},
              fwd_expect(id_rs1, mem_ok, mem_val));
        check("fwd_id_rs2", {fwd_id_rs2_hit, fwd_id_rs2_data},
              fwd_expect(id_rs2, mem_ok, mem_val));
    endtask

    // bubble cycle in which nothing may stall or retire
    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_outputs(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    // fill_word >= 0 forces an aligned word store to that word
    task automatic run_instr(input int fill_word);
        int                kind;
        int                waited;
        logic [2:0]        f3;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  rs2;
        logic [`XLEN-1:0]  load_val;
        logic [3:0][7:0]   w;
        logic [`REG_W-1:0] src [4];
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] wbr;
        logic              mis;
        logic              load;
        logic              wr;

        // 0 alu, 1 load, 2 store
        kind = $urandom_range(2);
        f3   = 3'($urandom_range(2));
        addr = {22'd0, 8'($urandom_range(N_WORDS - 1)), 2'b00};
        if (f3 == `F3_LB) begin
            addr[1:0] = 2'($urandom);
        end else if (f3 == `F3_LH) begin
            addr[1] = 1'($urandom);
        end
        mis = f3 != `F3_LB && $urandom_range(9) == 0;
        if (mis) begin
            addr[1:0] = {1'($urandom), 1'b1};
        end
        if (kind == 1 && f3 != `F3_LW && $urandom_range(1) == 1) begin
            f3[2] = 1'b1;
        end
        if (fill_word >= 0) begin
            kind = 2;
            f3   = `F3_SW;
            addr = 32'(fill_word) << 2;
            mis  = 1'b0;
        end else if (kind == 0) begin
            addr = $urandom;
            f3   = 3'($urandom);
            mis  = 1'b0;
        end
        load = kind == 1 && !mis;
        wr   = kind == 1 || (kind == 0 && $urandom_range(3) != 0);
        rd   = 5'($urandom);
        wbr  = ($urandom_range(2) == 0) ? rd : 5'($urandom);
        rs2  = $urandom;
        for (int i = 0; i < 4; i++) begin
            case ($urandom_range(3))
                0:       src[i] = rd;
                1:       src[i] = wbr;
                2:       src[i] = '0;
                default: src[i] = 5'($urandom);
            endcase
        end
        w = mem_model[addr[7:2]];
        case (f3)
            `F3_LB:  load_val = {{24{w[addr[1:0]][7]}}, w[addr[1:0]]};
            `F3_LBU: load_val = {24'd0, w[addr[1:0]]};
            `F3_LH:  load_val = {{16{w[{addr[1], 1'b1}][7]}}, w[{addr[1], 1'b1}],
                                 w[{addr[1], 1'b0}]};
            `F3_LHU: load_val = {16'd0, w[{addr[1], 1'b1}], w[{addr[1], 1'b0}]};
            default: load_val = w;
        endcase

        @(posedge clk);
        {in_valid, in_pc, in_alu_out, in_rs2_data, in_rd, in_write_gpr} <=
            {1'b1, 32'($urandom), addr, rs2, rd, wr};
        {in_mem_read, in_mem_write, in_funct3} <= {kind == 1, kind == 2, f3};
        {wb_rd, wb_write_gpr, wb_data} <= {wbr, 1'($urandom), 32'($urandom)};
        {ex_rs1, ex_rs2, id_rs1, id_rs2} <= {src[0], src[1], src[2], src[3]};
        @(negedge clk);
        // a load gives no MEM hit before its data is back
        check_outputs(load, !load, mis, addr, wr && kind != 1, addr);

        waited = 0;
        while (stall && waited < WAIT_MAX) begin
            @(posedge clk);
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("timeout at t=%0t, stall never cleared", $time);
            timeouts++;
        end else if (load && waited == 1) begin
            check_outputs(1'b0, 1'b1, 1'b0, load_val, 1'b1, load_val);
        end else if (load) begin
            errors++;
            $display("load at %h stalled for %0d cycles instead of one", addr, waited);
        end

        if (kind == 2 && !mis) begin
            if (f3 == `F3_SB) begin
                mem_model[addr[7:2]][addr[1:0]] = rs2[7:0];
            end else if (f3 == `F3_SH) begin
                mem_model[addr[7:2]][{addr[1], 1'b0}] = rs2[7:0];
                mem_model[addr[7:2]][{addr[1], 1'b1}] = rs2[15:8];
            end else begin
                mem_model[addr[7:2]] = rs2;
            end
        end
    endtask

    // ==============================
    // main sequence
    initial begin
        void'($urandom(32'h3cbe_7e1b));
        errors   = 0;
        timeouts = 0;
        arst_n   = 1'b0;
        {in_valid, in_pc, in_alu_out, in_rs2_data, in_rd, in_write_gpr, in_mem_read,
         in_mem_write, in_funct3, wb_rd, wb_write_gpr, wb_data} = '0;
        {ex_rs1, ex_rs2, id_rs1, id_rs2} = '0;
        repeat (15) begin
            idle_cycle();
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) begin
            idle_cycle();
        end
        for (int i = 0; i < N_WORDS && timeouts == 0; i++) begin
            run_instr(i);
        end
        for (int n = 0; n < N_INSTR && timeouts == 0; n++) begin
            if ($urandom_range(7) == 0) begin
                idle_cycle();
            end
            run_instr(-1);
        end
        $display("%0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
+incdir+logic
logic/mem_pkg.sv
logic/data_ram.sv
logic/mem_align.sv
logic/mem_ctrl.sv
logic/fwd_unit.sv
logic/mem_stage.sv
verif/mem_stage_assert.sv
verif/mem_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the memory stage, every variable can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
